/* Makefile */
VERILATOR ?= verilator
TOP ?= store_unit_tb
RTL_TOP ?= store_unit_top
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status of the simulation is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(shell grep '^source/' $(FILELIST)) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
source/tomasulo_pkg.sv
source/issue_ctrl.sv
source/tag_counter.sv
source/reg_status.sv
source/store_stations.sv
source/store_unit_top.sv
tests/tb_clock.sv
tests/store_unit_tb.sv

/* source/issue_ctrl.sv */
module issue_ctrl import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input word_t inst,
	input logic tags_full,
	input tag_t next_tag,
	input logic [station_count-1:0] slot_busy,
	input logic cdb_valid,
	input tag_t cdb_tag,
	output logic stall,
	output reg_idx_t rd_a,
	output reg_idx_t rd_b,
	output reg_idx_t rd_c,
	output logic rs_set_en,
	output reg_idx_t rs_set_idx,
	output word_t rs_set_value,
	output logic rs_pend_en,
	output reg_idx_t rs_pend_idx,
	output tag_t rs_pend_tag,
	output logic tag_alloc,
	output logic st_load,
	output logic [station_index_width-1:0] st_load_slot,
	output logic st_offset_imm,
	output word_t st_imm
);

	opcode_t op;
	logic is_store, slot_free, tag_block;
	logic station_wait, tag_wait, accept;
	logic [station_index_width-1:0] free_slot;

	assign op = opcode_t'(inst[op_hi:op_lo]);
	assign is_store = (op == op_swi) || (op == op_swr);
	assign slot_free = ~&slot_busy;
	// a broadcast of the tag about to be reused is still live this cycle
	assign tag_block = tags_full || (cdb_valid && cdb_tag == next_tag);
	assign station_wait = inst_valid && is_store && !slot_free;
	assign tag_wait = inst_valid && op == op_wait && tag_block;

	always_comb begin
		free_slot = '0;
		for (int i = station_count - 1; i >= 0; i--) begin
			if (!slot_busy[i])
				free_slot = station_index_width'(i); // lowest free wins
		end
	end

	// held until the slot or tag frees, source keeps the instruction
	assign stall = station_wait || tag_wait;

	assign accept = inst_valid && !stall;

	// read ports straight from the fields
	assign rd_a = inst[rd_hi:rd_lo];
	assign rd_b = inst[rb_hi:rb_lo];
	assign rd_c = inst[rx_hi:rx_lo];

	assign rs_set_en = accept && op == op_set;
	assign rs_set_idx = inst[rd_hi:rd_lo];
	assign rs_set_value = word_t'(inst[imm8_hi:0]);
	assign rs_pend_en = accept && op == op_wait;
	assign rs_pend_idx = inst[rd_hi:rd_lo];
	assign rs_pend_tag = next_tag;
	assign tag_alloc = rs_pend_en;

	assign st_load = accept && is_store;
	assign st_load_slot = free_slot;
	assign st_offset_imm = op == op_swi;
	assign st_imm = word_t'(inst[imm7_hi:0]);

endmodule

/* source/reg_status.sv */
module reg_status import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rs_set_en,
	input reg_idx_t rs_set_idx,
	input word_t rs_set_value,
	input logic rs_pend_en,
	input reg_idx_t rs_pend_idx,
	input tag_t rs_pend_tag,
	input logic cdb_valid,
	input tag_t cdb_tag,
	input word_t cdb_value,
	input reg_idx_t rd_a,
	input reg_idx_t rd_b,
	input reg_idx_t rd_c,
	output word_t val_a,
	output word_t val_b,
	output word_t val_c,
	output tag_t tag_a,
	output tag_t tag_b,
	output tag_t tag_c
);

	word_t values [reg_count];
	tag_t tags [reg_count];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				values[i] <= '0;
				tags[i] <= tag_ready;
			end
		end else begin
			for (int i = 0; i < reg_count; i++) begin
				if (rs_set_en && rs_set_idx == reg_idx_t'(i)) begin
					values[i] <= rs_set_value;
					tags[i] <= tag_ready;
				end else if (rs_pend_en && rs_pend_idx == reg_idx_t'(i)) begin
					tags[i] <= rs_pend_tag; // value kept, only the tag moves
				end else if (cdb_valid && tags[i] != tag_ready && tags[i] == cdb_tag) begin
					values[i] <= cdb_value;
					tags[i] <= tag_ready;
				end
			end
		end
	end

	// no bus bypass here, the stations forward
	assign val_a = values[rd_a];
	assign val_b = values[rd_b];
	assign val_c = values[rd_c];
	assign tag_a = tags[rd_a];
	assign tag_b = tags[rd_b];
	assign tag_c = tags[rd_c];

endmodule

/* source/store_stations.sv */
module store_stations import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic st_load,
	input logic [station_index_width-1:0] st_load_slot,
	input logic st_offset_imm,
	input word_t st_imm,
	input word_t st_base_val,
	input tag_t st_base_tag,
	input word_t st_data_val,
	input tag_t st_data_tag,
	input word_t st_idx_val,
	input tag_t st_idx_tag,
	input logic cdb_valid,
	input tag_t cdb_tag,
	input word_t cdb_value,
	output logic [station_count-1:0] slot_busy,
	output logic store_valid,
	output word_t store_addr,
	output word_t store_data
);

	word_t base_val [station_count];
	word_t off_val [station_count];
	word_t data_val [station_count];
	tag_t base_tag [station_count];
	tag_t off_tag [station_count];
	tag_t data_tag [station_count];

	// operands as seen after this cycle's broadcast
	word_t base_now [station_count];
	word_t off_now [station_count];
	word_t data_now [station_count];
	logic [station_count-1:0] cand;
	logic found;
	logic [station_index_width-1:0] sel;

	function automatic logic cdb_hit(tag_t t);
		return cdb_valid && t != tag_ready && t == cdb_tag;
	endfunction

	always_comb begin
		for (int i = 0; i < station_count; i++) begin
			base_now[i] = cdb_hit(base_tag[i]) ? cdb_value : base_val[i];
			off_now[i] = cdb_hit(off_tag[i]) ? cdb_value : off_val[i];
			data_now[i] = cdb_hit(data_tag[i]) ? cdb_value : data_val[i];
			cand[i] = slot_busy[i]
				&& (base_tag[i] == tag_ready || cdb_hit(base_tag[i]))
				&& (off_tag[i] == tag_ready || cdb_hit(off_tag[i]))
				&& (data_tag[i] == tag_ready || cdb_hit(data_tag[i]));
		end
	end

	always_comb begin
		found = |cand;
		sel = '0;
		for (int i = station_count - 1; i >= 0; i--) begin
			if (cand[i])
				sel = station_index_width'(i); // lower slot first
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			slot_busy <= '0;
			store_valid <= 1'b0;
		end else begin
			store_valid <= found;
			for (int i = 0; i < station_count; i++) begin
				if (st_load && st_load_slot == station_index_width'(i))
					slot_busy[i] <= 1'b1;
				else if (found && sel == station_index_width'(i))
					slot_busy[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			store_addr <= base_now[sel] + off_now[sel];
			store_data <= data_now[sel];
		end
		for (int i = 0; i < station_count; i++) begin
			if (st_load && st_load_slot == station_index_width'(i)) begin
				// capture, with a same-cycle broadcast already applied
				base_val[i] <= cdb_hit(st_base_tag) ? cdb_value : st_base_val;
				base_tag[i] <= cdb_hit(st_base_tag) ? tag_ready : st_base_tag;
				data_val[i] <= cdb_hit(st_data_tag) ? cdb_value : st_data_val;
				data_tag[i] <= cdb_hit(st_data_tag) ? tag_ready : st_data_tag;
				if (st_offset_imm) begin
					off_val[i] <= st_imm;
					off_tag[i] <= tag_ready;
				end else begin
					off_val[i] <= cdb_hit(st_idx_tag) ? cdb_value : st_idx_val;
					off_tag[i] <= cdb_hit(st_idx_tag) ? tag_ready : st_idx_tag;
				end
			end else begin
				base_val[i] <= base_now[i];
				off_val[i] <= off_now[i];
				data_val[i] <= data_now[i];
				if (cdb_hit(base_tag[i])) base_tag[i] <= tag_ready;
				if (cdb_hit(off_tag[i])) off_tag[i] <= tag_ready;
				if (cdb_hit(data_tag[i])) data_tag[i] <= tag_ready;
			end
		end
	end

endmodule

/* source/store_unit_top.sv */
module store_unit_top import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input word_t inst,
	output logic stall,
	input logic cdb_valid,
	input tag_t cdb_tag,
	input word_t cdb_value,
	output logic store_valid,
	output word_t store_addr,
	output word_t store_data
);

	reg_idx_t rd_a, rd_b, rd_c;
	word_t val_a, val_b, val_c;
	tag_t tag_a, tag_b, tag_c;
	logic rs_set_en, rs_pend_en;
	reg_idx_t rs_set_idx, rs_pend_idx;
	word_t rs_set_value;
	tag_t rs_pend_tag;
	logic tag_alloc, tags_full;
	tag_t next_tag;
	logic st_load, st_offset_imm;
	logic [station_index_width-1:0] st_load_slot;
	word_t st_imm;
	logic [station_count-1:0] slot_busy;

	issue_ctrl u_issue (
		.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
		.tags_full(tags_full), .next_tag(next_tag), .slot_busy(slot_busy),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .stall(stall),
		.rd_a(rd_a), .rd_b(rd_b), .rd_c(rd_c),
		.rs_set_en(rs_set_en), .rs_set_idx(rs_set_idx), .rs_set_value(rs_set_value),
		.rs_pend_en(rs_pend_en), .rs_pend_idx(rs_pend_idx), .rs_pend_tag(rs_pend_tag),
		.tag_alloc(tag_alloc), .st_load(st_load), .st_load_slot(st_load_slot),
		.st_offset_imm(st_offset_imm), .st_imm(st_imm)
	);

	tag_counter u_tags (
		.clk(clk), .reset(reset), .tag_alloc(tag_alloc), .cdb_valid(cdb_valid),
		.next_tag(next_tag), .tags_full(tags_full)
	);

	// port a is the store data, b the base, c the index
	reg_status u_regs (
		.clk(clk), .reset(reset),
		.rs_set_en(rs_set_en), .rs_set_idx(rs_set_idx), .rs_set_value(rs_set_value),
		.rs_pend_en(rs_pend_en), .rs_pend_idx(rs_pend_idx), .rs_pend_tag(rs_pend_tag),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.rd_a(rd_a), .rd_b(rd_b), .rd_c(rd_c),
		.val_a(val_a), .val_b(val_b), .val_c(val_c),
		.tag_a(tag_a), .tag_b(tag_b), .tag_c(tag_c)
	);

	store_stations u_stations (
		.clk(clk), .reset(reset), .st_load(st_load), .st_load_slot(st_load_slot),
		.st_offset_imm(st_offset_imm), .st_imm(st_imm),
		.st_base_val(val_b), .st_base_tag(tag_b), .st_data_val(val_a), .st_data_tag(tag_a),
		.st_idx_val(val_c), .st_idx_tag(tag_c),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.slot_busy(slot_busy), .store_valid(store_valid),
		.store_addr(store_addr), .store_data(store_data)
	);

endmodule

/* source/tag_counter.sv */
module tag_counter import tomasulo_pkg::*; (
	input logic clk,
	input logic reset,
	input logic tag_alloc,
	input logic cdb_valid,
	output tag_t next_tag,
	output logic tags_full
);

	logic [$clog2(tag_count)-1:0] ptr;
	logic [tag_width-1:0] outstanding;

	assign next_tag = tag_t'(ptr);
	assign tags_full = outstanding == tag_width'(tag_count);

	// pointer wraps by itself, tag_count is a power of two
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			ptr <= '0;
		else if (tag_alloc)
			ptr <= ptr + 1'b1;
	end

	// every broadcast retires one outstanding tag
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			outstanding <= '0;
		end else begin
			case ({tag_alloc, cdb_valid})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding; // both or neither
			endcase
		end
	end

endmodule

/* source/tomasulo_pkg.sv */
package tomasulo_pkg;

	localparam int word_width = 16;

	localparam int reg_count = 8;
	localparam int reg_index_width = 3;

	// one code above the real tags is kept free for "value present"
	localparam int tag_count = 8;
	localparam int tag_width = 4;
	localparam logic [tag_width-1:0] tag_ready = '1;

	localparam int station_count = 2;
	localparam int station_index_width = 1;

	localparam int opcode_width = 2;

	// instruction fields
	localparam int op_hi = 15;
	localparam int op_lo = 14;
	localparam int rd_hi = 13; // rd for set/wait, rs for stores
	localparam int rd_lo = 11;
	localparam int rb_hi = 10;
	localparam int rb_lo = 8;
	localparam int rx_hi = 7;
	localparam int rx_lo = 5;
	localparam int imm7_hi = 6;
	localparam int imm8_hi = 7;

	typedef logic [word_width-1:0] word_t;
	typedef logic [tag_width-1:0] tag_t;
	typedef logic [reg_index_width-1:0] reg_idx_t;

	typedef enum logic [opcode_width-1:0] {
		op_set = 2'd0,
		op_wait = 2'd1,
		op_swi = 2'd2,
		op_swr = 2'd3
	} opcode_t;

endpackage

/* tests/store_stim.txt */
# kinds: I inst, B tag value, E addr data, S stall, W idle cycles; fields in hex
# a B line goes out together with the next I or W cycle
E 0015 005a
E 006a 0010
I 0810
I 105a
I 9105
I ca20
E 0030 1234
I 6800
I a920
W 3
B 0 1234
W 1
E 0052 00aa
I 7800
B 1 00aa
I b942
E 0011 0c0c
E 0012 0b0b
E 0016 005a
I 6800
I 7000
I a901
I b102
S 1
I 9106
S 1
B 3 0b0b
W 1
S 0
W 1
B 2 0c0c
W 1
I 4000
I 4800
I 5000
I 5800
I 6000
I 6800
I 7000
I 7800
S 1
I 4000
B 4 0111
W 1
S 0
W 1
E 099a 0999
B 4 0999
W 1
I 8001

/* tests/store_unit_tb.sv */
module store_unit_tb import tomasulo_pkg::*; ();

	localparam string stim_path = "tests/store_stim.txt";
	localparam int drive_delay = 2;
	localparam int reset_cycles = 5;
	localparam int drain_cycles = 6;

	logic clk, reset;
	logic inst_valid, stall;
	word_t inst;
	logic cdb_valid;
	tag_t cdb_tag;
	word_t cdb_value;
	logic store_valid;
	word_t store_addr, store_data;

	// script state carried between cycles
	logic inst_held, bcast_pending, stall_armed, stall_expected;
	word_t held_word, bcast_value;
	tag_t bcast_tag;
	word_t exp_addr[$];
	word_t exp_data[$];
	logic [31:0] rng_state = 32'hf62a;
	int cycle_count = 0;
	int cycle_limit = 100;

	tb_clock clock_gen (.clk(clk));

	store_unit_top dut (
		.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst), .stall(stall),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.store_valid(store_valid), .store_addr(store_addr), .store_data(store_data)
	);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_word(input string what, input word_t got, input word_t expected);
		if (got !== expected)
			stop_with_failure($sformatf("mismatch at time %0t: %s is %h, expected %h",
				$time, what, got, expected));
	endtask

	task automatic check_flag(input string what, input logic got, input logic expected);
		if (got !== expected)
			stop_with_failure($sformatf("mismatch at time %0t: %s is %b, expected %b",
				$time, what, got, expected));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// stores may leave out of order, so look them up by address
	task automatic match_store(input word_t addr, input word_t data);
		int hit;
		hit = -1;
		for (int i = 0; i < exp_addr.size(); i++) begin
			if (exp_addr[i] == addr)
				hit = i;
		end
		if (hit < 0) begin
			stop_with_failure($sformatf("mismatch at time %0t: store to unexpected address %h",
				$time, addr));
		end else begin
			check_word("store data", data, exp_data[hit]);
			exp_addr.delete(hit);
			exp_data.delete(hit);
		end
	endtask

	// one clock cycle, entered and left just after the rising edge
	task automatic step_cycle(input bit check_stall);
		logic stall_seen;
		inst_valid = inst_held;
		inst = held_word;
		cdb_valid = bcast_pending;
		cdb_tag = bcast_tag;
		cdb_value = bcast_value;
		bcast_pending = 1'b0;
		@(negedge clk);
		stall_seen = stall;
		if (check_stall && stall_armed) begin
			check_flag("stall", stall_seen, stall_expected);
			stall_armed = 1'b0;
		end
		@(posedge clk);
		if (inst_held && !stall_seen)
			inst_held = 1'b0; // taken at this edge
		#drive_delay;
		inst_valid = inst_held;
		cdb_valid = 1'b0;
	endtask

	task automatic run_command(input logic [7:0] kind, input logic [31:0] a,
		input logic [31:0] b);
		case (kind)
			"I": begin
				while (inst_held)
					step_cycle(1'b0);
				if (!bcast_pending) begin // a queued broadcast rides with this inst
					rng_state = xorshift32(rng_state);
					repeat (rng_state[1:0]) step_cycle(1'b0);
				end
				inst_held = 1'b1;
				held_word = word_t'(a);
				step_cycle(1'b1);
			end
			"B": begin
				if (bcast_pending)
					step_cycle(1'b0); // one broadcast per cycle
				bcast_pending = 1'b1;
				bcast_tag = tag_t'(a);
				bcast_value = word_t'(b);
			end
			"E": begin
				exp_addr.push_back(word_t'(a));
				exp_data.push_back(word_t'(b));
			end
			"S": begin
				stall_armed = 1'b1;
				stall_expected = a[0];
			end
			default: repeat (a) step_cycle(1'b1); // W
		endcase
	endtask

	always @(negedge clk) begin
		if (!reset && store_valid)
			match_store(store_addr, store_data);
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit)
			stop_with_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
	end

	initial begin
		int fd, ch, got, line_count;
		logic [7:0] kind;
		logic [31:0] field_a, field_b;
		bit done;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		inst_held = 1'b0;
		held_word = '0;
		bcast_pending = 1'b0;
		bcast_tag = '0;
		bcast_value = '0;
		stall_armed = 1'b0;
		stall_expected = 1'b0;
		field_b = '0;
		line_count = 0;
		done = 1'b0;
		fd = $fopen(stim_path, "r");
		if (fd == 0)
			stop_with_failure("cannot open the stimulus file");
		ch = $fgetc(fd);
		while (ch != -1) begin
			if (ch == 10)
				line_count++;
			ch = $fgetc(fd);
		end
		$fclose(fd);
		cycle_limit = 10 * line_count + 100;
		fd = $fopen(stim_path, "r");
		repeat (reset_cycles) @(posedge clk);
		#drive_delay reset = 1'b0;
		while (!done) begin
			got = $fscanf(fd, "%s", kind);
			if (got != 1) begin
				done = 1'b1;
			end else if (kind == "#") begin
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end else begin
				case (kind)
					"I", "S", "W": got = $fscanf(fd, "%h", field_a) + 1;
					"B", "E": got = $fscanf(fd, "%h %h", field_a, field_b);
					default: got = 0;
				endcase
				if (got != 2)
					stop_with_failure("malformed or unknown line in the stimulus file");
				run_command(kind, field_a, field_b);
			end
		end
		$fclose(fd);
		while (inst_held || bcast_pending)
			step_cycle(1'b0);
		repeat (drain_cycles) step_cycle(1'b0);
		if (exp_addr.size() != 0) begin
			stop_with_failure($sformatf("%0d expected stores never appeared", exp_addr.size()));
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* tests/tb_clock.sv */
module tb_clock #(
	parameter int period = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule
